// ==== Makefile ====
# Verilator build and run of the MD5 pipeline testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := md5Tb
FILELIST  := filelist.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes.
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== common/md5RoundPkg.sv ====
// ******************************
// Per-step MD5 tables and lookup functions.
// Evaluated at elaboration time from each stage's STEP.
// ******************************
`include "md5_consts.svh"

package md5RoundPkg;

  import md5TypesPkg::*;

  // Round function opcode.
  typedef enum logic [1:0] {
    FuncF,
    FuncG,
    FuncH,
    FuncI
  } md5FuncE;

  localparam int ShiftsPerRound = 4;

  // Integer part of abs(sin(i + 1)) * 2^32.
  localparam md5WordT ConstTable [`MD5_STEPS] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
  };

  // Four rotate amounts per round that repeat through the round.
  localparam int ShiftTable [4 * ShiftsPerRound] = '{
    7, 12, 17, 22,
    5, 9, 14, 20,
    4, 11, 16, 23,
    6, 10, 15, 21
  };

  function automatic md5FuncE stepFunc(input int step);
    md5FuncE func;
    case (step / `MD5_ROUND_STEPS)
      0: func = FuncF;
      1: func = FuncG;
      2: func = FuncH;
      default: func = FuncI;
    endcase
    return func;
  endfunction

  function automatic md5WordT stepConst(input int step);
    return ConstTable[step];
  endfunction

  function automatic int stepShift(input int step);
    int round;
    round = step / `MD5_ROUND_STEPS;
    return ShiftTable[round * ShiftsPerRound + step % ShiftsPerRound];
  endfunction

  // Message word used by each step.
  function automatic int stepMsgIndex(input int step);
    int idx;
    case (step / `MD5_ROUND_STEPS)
      0: idx = step;
      1: idx = 5 * step + 1;
      2: idx = 3 * step + 5;
      default: idx = 7 * step;
    endcase
    return idx % `MD5_BLOCK_WORDS;
  endfunction

endpackage

// ==== common/md5TypesPkg.sv ====
// ******************************
// Data types shared by the MD5 pipeline stages.
// ******************************
`include "md5_consts.svh"

package md5TypesPkg;

  typedef logic [`MD5_WORD_W-1:0] md5WordT;

  // Word 0 is the least significant word of the input block.
  typedef md5WordT md5BlockT [`MD5_BLOCK_WORDS];

  // Working state passed from one stage to the next.
  typedef struct packed {
    md5WordT a;
    md5WordT b;
    md5WordT c;
    md5WordT d;
  } md5StateT;

endpackage

// ==== common/md5_consts.svh ====
// ******************************
// Sizes of the MD5 main loop.
// Include wherever widths or step counts are needed.
// ******************************
`ifndef MD5_CONSTS_SVH
`define MD5_CONSTS_SVH

// Width of one state or message word.
`define MD5_WORD_W 32

// One message block.
`define MD5_BLOCK_W 512

`define MD5_BLOCK_WORDS 16

// Operations in the main loop.
`define MD5_STEPS 64

// Four rounds of sixteen steps each.
`define MD5_ROUND_STEPS 16

`endif

// ==== filelist.f ====
+incdir+common
common/md5TypesPkg.sv
common/md5RoundPkg.sv
md5Core/md5Mix.sv
md5Core/md5Step.sv
md5Core/md5Core.sv
verif/tbClock.sv
verif/md5Tb.sv

// ==== md5Core/md5Core.sv ====
// ******************************
// Unrolled MD5 main loop, 64 stages.
// One block in per clock, results 64 clocks later.
// ******************************
`include "md5_consts.svh"

module md5Core
  import md5TypesPkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [`MD5_BLOCK_W-1:0] block,
  input  md5WordT                 a0,
  input  md5WordT                 b0,
  input  md5WordT                 c0,
  input  md5WordT                 d0,
  output md5WordT                 a64,
  output md5WordT                 b64,
  output md5WordT                 c64,
  output md5WordT                 d64
);

  // Entry k feeds stage k; the last entry is the pipeline output.
  md5StateT stateChain [`MD5_STEPS + 1];
  md5BlockT msgChain [`MD5_STEPS + 1];

  for (genvar w = 0; w < `MD5_BLOCK_WORDS; w++)
  begin : gSlice
    assign msgChain[0][w] = block[w * `MD5_WORD_W +: `MD5_WORD_W];
  end

  assign stateChain[0] = '{a: a0, b: b0, c: c0, d: d0};

  for (genvar k = 0; k < `MD5_STEPS; k++)
  begin : gStage
    md5Step #(
      .STEP(k)
    ) step (
      .clk     (clk),
      .rstN    (rstN),
      .stateIn (stateChain[k]),
      .msgIn   (msgChain[k]),
      .stateOut(stateChain[k + 1]),
      .msgOut  (msgChain[k + 1])
    );
  end

  assign a64 = stateChain[`MD5_STEPS].a;
  assign b64 = stateChain[`MD5_STEPS].b;
  assign c64 = stateChain[`MD5_STEPS].c;
  assign d64 = stateChain[`MD5_STEPS].d;

endmodule

// ==== md5Core/md5Mix.sv ====
// ******************************
// Combinational arithmetic of one MD5 step.
// ******************************
`include "md5_consts.svh"

module md5Mix
  import md5TypesPkg::*, md5RoundPkg::*;
#(
  parameter int STEP = 0
) (
  input  md5StateT stateIn,
  input  md5WordT  msgWord,
  output md5WordT  bNext
);

  localparam md5FuncE Func = stepFunc(STEP);
  localparam md5WordT StepK = stepConst(STEP);
  localparam int Shift = stepShift(STEP);

  md5WordT funcOut;
  md5WordT sum;
  md5WordT rotated;

  always_comb
  begin
    unique case (Func)
      FuncF: funcOut = (stateIn.b & stateIn.c) | (~stateIn.b & stateIn.d);
      FuncG: funcOut = (stateIn.d & stateIn.b) | (~stateIn.d & stateIn.c);
      FuncH: funcOut = stateIn.b ^ stateIn.c ^ stateIn.d;
      FuncI: funcOut = stateIn.c ^ (stateIn.b | ~stateIn.d);
      default: funcOut = '0;
    endcase
  end

  assign sum = stateIn.a + funcOut + StepK + msgWord;

  // Left rotate by the step's shift amount.
  assign rotated = (sum << Shift) | (sum >> (`MD5_WORD_W - Shift));

  assign bNext = stateIn.b + rotated;

endmodule

// ==== md5Core/md5Step.sv ====
// ******************************
// One registered MD5 pipeline stage.
// Carries the message block alongside the state.
// ******************************
module md5Step
  import md5TypesPkg::*, md5RoundPkg::*;
#(
  parameter int STEP = 0
) (
  input  logic     clk,
  input  logic     rstN,
  input  md5StateT stateIn,
  input  md5BlockT msgIn,
  output md5StateT stateOut,
  output md5BlockT msgOut
);

  localparam int MsgIdx = stepMsgIndex(STEP);

  md5WordT bNext;

  md5Mix #(
    .STEP(STEP)
  ) mix (
    .stateIn(stateIn),
    .msgWord(msgIn[MsgIdx]),
    .bNext  (bNext)
  );

  // State rotates one word per step.
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      stateOut <= '0;
      msgOut <= '{default: '0};
    end
    else
    begin
      stateOut.a <= stateIn.d;
      stateOut.b <= bNext;
      stateOut.c <= stateIn.b;
      stateOut.d <= stateIn.c;
      msgOut <= msgIn;
    end
  end

  stateKnownAssert: assert property (
    @(posedge clk) disable iff (!rstN)
    !$isunknown(stateIn)
  ) else $error("Stage %0d: unknown state at the input.", STEP);

  msgKnownAssert: assert property (
    @(posedge clk) disable iff (!rstN)
    !$isunknown(msgIn[MsgIdx])
  ) else $error("Stage %0d: unknown message word at the input.", STEP);

endmodule

// ==== verif/md5Tb.sv ====
// ******************************
// Testbench for the unrolled MD5 loop.
// Known answers, random streaming and reset.
// ******************************
`include "md5_consts.svh"

module md5Tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ResetCycles = 3;
  localparam int KnownCount = 2;
  localparam int StreamCount = 120;
  localparam int PostCount = 40;
  localparam int Margin = 20;
  // Every driven slot including the reset pulse.
  localparam int CycleLimit = ResetCycles + KnownCount + StreamCount + 1 + PostCount
                              + `MD5_STEPS + Margin;

  localparam logic [31:0] ChainA = 32'h67452301;
  localparam logic [31:0] ChainB = 32'hefcdab89;
  localparam logic [31:0] ChainC = 32'h98badcfe;
  localparam logic [31:0] ChainD = 32'h10325476;

  // Padded single blocks with word 0 in the low bits.
  localparam logic [`MD5_BLOCK_W-1:0] EmptyBlock = 512'h80;
  localparam logic [`MD5_BLOCK_W-1:0] AbcBlock = {32'd0, 32'd24, 416'd0, 32'h80636261};

  // Standard sine constants.
  localparam logic [31:0] SineK [64] = '{
    32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
    32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
    32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
    32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
    32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
    32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
    32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
    32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
    32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
    32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
    32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
    32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
    32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
    32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
    32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
    32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
  };

  localparam int RotAmount [16] = '{
    7, 12, 17, 22,
    5, 9, 14, 20,
    4, 11, 16, 23,
    6, 10, 15, 21
  };

  typedef struct packed {
    int due;
    logic [127:0] result;
  } expEntryT;

  logic clk;
  logic rstN;
  logic rstReq;
  logic [`MD5_BLOCK_W-1:0] block;
  logic [31:0] a0;
  logic [31:0] b0;
  logic [31:0] c0;
  logic [31:0] d0;
  logic [31:0] a64;
  logic [31:0] b64;
  logic [31:0] c64;
  logic [31:0] d64;

  logic inValid;
  logic [127:0] pendExp;
  logic chkDue;
  logic [127:0] expState;
  logic wasReset = 1'b0;
  logic [31:0] lfsrState;

  expEntryT expQ [$];
  expEntryT entry;
  expEntryT head;

  int cycle = 0;
  int mismatches = 0;
  int otherErrors = 0;
  int checksDone = 0;
  int discarded = 0;
  int maxInFlight = 0;

  tbClock #(
    .HalfPeriod (20),
    .ResetCycles(ResetCycles)
  ) clockGen (
    .rstReq(rstReq),
    .clk   (clk),
    .rstN  (rstN)
  );

  md5Core DUT (
    .clk  (clk),
    .rstN (rstN),
    .block(block),
    .a0   (a0),
    .b0   (b0),
    .c0   (c0),
    .d0   (d0),
    .a64  (a64),
    .b64  (b64),
    .c64  (c64),
    .d64  (d64)
  );

  // Galois LFSR stepped once per bit taken.
  function automatic logic [31:0] randWord();
    logic [31:0] w;
    int i;
    w = '0;
    for (i = 0; i < 32; i++)
    begin
      w[i] = lfsrState[0];
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
    end
    return w;
  endfunction

  function automatic logic [`MD5_BLOCK_W-1:0] randBlock();
    logic [`MD5_BLOCK_W-1:0] blk;
    int w;
    for (w = 0; w < `MD5_BLOCK_WORDS; w++)
    begin
      blk[w * 32 +: 32] = randWord();
    end
    return blk;
  endfunction

  // The 64 MD5 operations without the final addition. Returns {a, b, c, d}.
  function automatic logic [127:0] md5Model(input logic [`MD5_BLOCK_W-1:0] blk,
                                            input logic [31:0] ia, ib, ic, id);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] f;
    logic [31:0] sum;
    logic [31:0] tmp;
    int g;
    int s;
    int i;
    a = ia;
    b = ib;
    c = ic;
    d = id;
    for (i = 0; i < 64; i++)
    begin
      case (i / 16)
        0:
        begin
          f = (b & c) | (~b & d);
          g = i;
        end
        1:
        begin
          f = (d & b) | (~d & c);
          g = (5 * i + 1) % 16;
        end
        2:
        begin
          f = b ^ c ^ d;
          g = (3 * i + 5) % 16;
        end
        default:
        begin
          f = c ^ (b | ~d);
          g = (7 * i) % 16;
        end
      endcase
      s = RotAmount[(i / 16) * 4 + i % 4];
      sum = a + f + SineK[i] + blk[g * 32 +: 32];
      tmp = d;
      d = c;
      c = b;
      b = b + ((sum << s) | (sum >> (32 - s)));
      a = tmp;
    end
    return {a, b, c, d};
  endfunction

  task automatic applyItem(input logic [`MD5_BLOCK_W-1:0] blk,
                           input logic [31:0] ia, ib, ic, id,
                           input logic [127:0] expResult);
    @(negedge clk);
    rstReq = 1'b0;
    block = blk;
    a0 = ia;
    b0 = ib;
    c0 = ic;
    d0 = id;
    inValid = 1'b1;
    pendExp = expResult;
  endtask

  task automatic applyRandom();
    logic [`MD5_BLOCK_W-1:0] blk;
    logic [31:0] ia;
    logic [31:0] ib;
    logic [31:0] ic;
    logic [31:0] id;
    blk = randBlock();
    ia = randWord();
    ib = randWord();
    ic = randWord();
    id = randWord();
    applyItem(blk, ia, ib, ic, id, md5Model(blk, ia, ib, ic, id));
  endtask

  // Expected result is the published digest less the chaining words.
  task automatic applyKnown(input logic [`MD5_BLOCK_W-1:0] blk,
                            input logic [31:0] dA, dB, dC, dD);
    logic [127:0] expResult;
    expResult = {dA - ChainA, dB - ChainB, dC - ChainC, dD - ChainD};
    if (md5Model(blk, ChainA, ChainB, ChainC, ChainD) !== expResult)
    begin
      otherErrors++;
      $display("Software model does not reproduce a published digest.");
    end
    applyItem(blk, ChainA, ChainB, ChainC, ChainD, expResult);
  endtask

  // Records what the DUT sampled at this edge.
  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (!rstN)
    begin
      discarded = discarded + expQ.size();
      expQ.delete();
    end
    else if (inValid)
    begin
      entry.due = cycle + `MD5_STEPS;
      entry.result = pendExp;
      expQ.push_back(entry);
      if (expQ.size() > maxInFlight)
      begin
        maxInFlight = expQ.size();
      end
    end
  end

  always @(posedge clk)
  begin
    wasReset <= !rstN;
  end

  // Arms the check for the coming edge.
  always @(negedge clk)
  begin
    if (expQ.size() != 0 && expQ[0].due == cycle + 1)
    begin
      head = expQ.pop_front();
      expState = head.result;
      chkDue = 1'b1;
      checksDone++;
    end
    else
    begin
      chkDue = 1'b0;
    end
  end

  resultCheck: assert property (
    @(posedge clk) chkDue |-> ({a64, b64, c64, d64} == expState)
  ) else
  begin
    mismatches++;
    $display("MISMATCH at %0t: outputs %h %h %h %h, expected %h", $time,
             $sampled(a64), $sampled(b64), $sampled(c64), $sampled(d64),
             $sampled(expState));
  end

  resetCheck: assert property (
    @(posedge clk) wasReset |-> ({a64, b64, c64, d64} == 128'd0)
  ) else
  begin
    mismatches++;
    $display("MISMATCH at %0t: outputs %h %h %h %h not cleared by reset", $time,
             $sampled(a64), $sampled(b64), $sampled(c64), $sampled(d64));
  end

  initial
  begin
    while (cycle < CycleLimit) @(negedge clk);
    $display("Timeout: the run did not finish within %0d cycles.", CycleLimit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    rstReq = 1'b0;
    block = '0;
    a0 = '0;
    b0 = '0;
    c0 = '0;
    d0 = '0;
    inValid = 1'b0;
    pendExp = '0;
    chkDue = 1'b0;
    expState = '0;
    lfsrState = 32'h74a6538d;

    wait (rstN === 1'b1);
    applyKnown(EmptyBlock, 32'hd98c1dd4, 32'h04b2008f, 32'h980980e9, 32'h7e42f8ec);
    applyKnown(AbcBlock, 32'h98500190, 32'hb04fd23c, 32'h7d3f96d6, 32'h727fe128);
    repeat (StreamCount) applyRandom();

    // One-cycle reset with the pipeline full.
    @(negedge clk);
    rstReq = 1'b1;
    inValid = 1'b0;
    repeat (PostCount) applyRandom();

    @(negedge clk);
    inValid = 1'b0;
    while (expQ.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);

    if (maxInFlight < `MD5_STEPS)
    begin
      otherErrors++;
      $display("Pipeline never held %0d items at once.", `MD5_STEPS);
    end
    if (discarded == 0)
    begin
      otherErrors++;
      $display("Reset in mid-stream discarded no items in flight.");
    end

    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             checksDone, mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== verif/tbClock.sv ====
// ******************************
// Testbench clock and power-on reset.
// rstReq pulls reset low again at any time.
// ******************************
module tbClock
#(
  parameter int HalfPeriod = 20,
  parameter int ResetCycles = 3
) (
  input  logic rstReq,
  output logic clk,
  output logic rstN
);

  timeunit 1ns;
  timeprecision 1ps;

  logic porDone;

  initial
  begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // Released on a falling edge away from the sampling edge.
  initial
  begin
    porDone = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    porDone = 1'b1;
  end

  assign rstN = porDone && !rstReq;

endmodule
